/* clint_msip.sv */
// Per-hart software interrupt bits with direct write, broadcast set and single clear
module clint_msip (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  clint_pkg::bus_data_t  wdata_i,
    input  clint_pkg::hart_idx_t  hart_i,
    input  logic                  msip_we_i,
    input  logic                  bcast_we_i,
    input  logic                  clr_we_i,
    output clint_pkg::hart_mask_t ipi_o
);

    clint_pkg::hart_mask_t msip_q;
    clint_pkg::hart_mask_t bcast_mask;
    clint_pkg::hart_mask_t clr_mask;
    logic [7:0]            first_hart;
    logic [7:0]            last_hart;
    logic [7:0]            clr_hart;

    // Fields of the broadcast and clear words
    assign last_hart  = wdata_i[7:0];
    assign first_hart = wdata_i[15:8];
    assign clr_hart   = wdata_i[7:0];

    // ----------------------------------------
    // Hart masks
    // ----------------------------------------

    // first > last gives an empty mask, an index past the last hart matches nothing
    always_comb begin
        for (int unsigned i = 0; i < clint_pkg::NUM_HARTS; i++) begin
            bcast_mask[i] = (first_hart <= 8'(i)) && (8'(i) <= last_hart);
            clr_mask[i]   = (clr_hart == 8'(i));
        end
    end

    // ----------------------------------------
    // Pending bits
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            msip_q <= '0;
        end else if (msip_we_i) begin
            msip_q[hart_i] <= wdata_i[0];
        end else if (bcast_we_i) begin
            msip_q <= msip_q | bcast_mask;
        end else if (clr_we_i) begin
            msip_q <= msip_q & ~clr_mask;
        end
    end

    assign ipi_o = msip_q;

endmodule

/* clint_mtime.sv */
// Machine timer, counts rtc ticks and accepts bus writes of either half
module clint_mtime (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 rtc_tick_i,
    input  clint_pkg::bus_data_t wdata_i,
    input  logic                 lo_we_i,
    input  logic                 hi_we_i,
    output clint_pkg::time_t     mtime_o
);

    clint_pkg::time_t mtime_q;
    clint_pkg::time_t mtime_inc;

    assign mtime_inc = mtime_q + clint_pkg::time_t'(1);

    // ----------------------------------------
    // Counter
    // ----------------------------------------

    // Bus writes win over a tick in the same cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mtime_q <= '0;
        end else if (lo_we_i) begin
            mtime_q[0 +: clint_pkg::DATA_W] <= wdata_i;
        end else if (hi_we_i) begin
            mtime_q[clint_pkg::DATA_W +: clint_pkg::DATA_W] <= wdata_i;
        end else if (rtc_tick_i) begin
            mtime_q <= mtime_inc;
        end
    end

    assign mtime_o = mtime_q;

endmodule

/* clint_pkg.sv */
// Core-local interrupt controller shared sizes, register map and types
package clint_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------

    localparam int unsigned NUM_HARTS   = 4;
    localparam int unsigned HART_IDX_W  = 2;
    localparam int unsigned ADDR_W      = 16;
    localparam int unsigned DATA_W      = 32;
    localparam int unsigned TIME_W      = 64;

    // Depth of the rtc input synchronizer
    localparam int unsigned SYNC_STAGES = 2;

    // ----------------------------------------
    // Types
    // ----------------------------------------

    typedef logic [TIME_W-1:0]     time_t;
    typedef logic [NUM_HARTS-1:0]  hart_mask_t;
    typedef logic [HART_IDX_W-1:0] hart_idx_t;
    typedef logic [DATA_W-1:0]     bus_data_t;
    typedef logic [ADDR_W-1:0]     bus_addr_t;

    // ----------------------------------------
    // Register map, byte offsets
    // ----------------------------------------

    // One msip word per hart, stride 4
    localparam bus_addr_t MSIP_BASE      = 16'h0000;

    // Set msip of harts first..last, first in bits 15..8 and last in bits 7..0
    localparam bus_addr_t MSIP_BCAST_OFS = 16'h0800;

    // Clear msip of the hart in bits 7..0
    localparam bus_addr_t MSIP_CLR_OFS   = 16'h0804;

    // Compare pairs at stride 8, low word first
    localparam bus_addr_t MTIMECMP_BASE  = 16'h4000;

    localparam bus_addr_t MTIME_LO_OFS   = 16'hBFF8;
    localparam bus_addr_t MTIME_HI_OFS   = 16'hBFFC;

endpackage

/* clint_reg_bus.sv */
// Register bus front end: handshake, address decode, read mux and response register
module clint_reg_bus (
    input  logic                                          clk_i,
    input  logic                                          reset_i,

    // Request channel
    input  logic                                          req_valid_i,
    output logic                                          req_ready_o,
    input  clint_pkg::bus_addr_t                          req_addr_i,
    input  logic                                          req_write_i,
    input  clint_pkg::bus_data_t                          req_wdata_i,

    // Response channel
    output logic                                          rsp_valid_o,
    input  logic                                          rsp_ready_i,
    output clint_pkg::bus_data_t                          rsp_rdata_o,
    output logic                                          rsp_error_o,

    // Register values for reads
    input  clint_pkg::time_t                              mtime_i,
    input  clint_pkg::time_t [clint_pkg::NUM_HARTS-1:0]   mtimecmp_i,
    input  clint_pkg::hart_mask_t                         msip_i,

    // Write side towards the register blocks
    output clint_pkg::bus_data_t                          wdata_o,
    output clint_pkg::hart_idx_t                          hart_o,
    output logic                                          mtime_lo_we_o,
    output logic                                          mtime_hi_we_o,
    output logic                                          cmp_lo_we_o,
    output logic                                          cmp_hi_we_o,
    output logic                                          msip_we_o,
    output logic                                          bcast_we_o,
    output logic                                          clr_we_o
);

    logic                 accept;
    logic                 wr;
    clint_pkg::bus_addr_t msip_ofs;
    clint_pkg::bus_addr_t cmp_ofs;
    clint_pkg::hart_idx_t msip_idx;
    clint_pkg::hart_idx_t cmp_idx;
    logic                 msip_hit;
    logic                 bcast_hit;
    logic                 clr_hit;
    logic                 cmp_hit;
    logic                 mtime_lo_hit;
    logic                 mtime_hi_hit;
    logic                 error;
    clint_pkg::bus_data_t rdata;

    logic                 rsp_valid_q;
    logic                 rsp_error_q;
    clint_pkg::bus_data_t rsp_rdata_q;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------

    assign msip_ofs = req_addr_i - clint_pkg::MSIP_BASE;
    assign cmp_ofs  = req_addr_i - clint_pkg::MTIMECMP_BASE;
    assign msip_idx = msip_ofs[2 +: clint_pkg::HART_IDX_W];
    assign cmp_idx  = cmp_ofs[3 +: clint_pkg::HART_IDX_W];

    assign msip_hit = (msip_ofs < clint_pkg::bus_addr_t'(4 * clint_pkg::NUM_HARTS))
                   && (msip_ofs[1:0] == 2'b00);
    assign cmp_hit  = (cmp_ofs < clint_pkg::bus_addr_t'(8 * clint_pkg::NUM_HARTS))
                   && (cmp_ofs[1:0] == 2'b00);

    assign bcast_hit    = (req_addr_i == clint_pkg::MSIP_BCAST_OFS);
    assign clr_hit      = (req_addr_i == clint_pkg::MSIP_CLR_OFS);
    assign mtime_lo_hit = (req_addr_i == clint_pkg::MTIME_LO_OFS);
    assign mtime_hi_hit = (req_addr_i == clint_pkg::MTIME_HI_OFS);

    assign error = !(msip_hit || cmp_hit || bcast_hit || clr_hit
                     || mtime_lo_hit || mtime_hi_hit);

    // ----------------------------------------
    // Write strobes
    // ----------------------------------------

    assign req_ready_o = ~rsp_valid_q;
    assign accept      = req_valid_i & req_ready_o;
    assign wr          = accept & req_write_i;

    assign wdata_o = req_wdata_i;
    assign hart_o  = cmp_hit ? cmp_idx : msip_idx;

    assign msip_we_o     = wr & msip_hit;
    assign bcast_we_o    = wr & bcast_hit;
    assign clr_we_o      = wr & clr_hit;
    assign cmp_lo_we_o   = wr & cmp_hit & ~cmp_ofs[2];
    assign cmp_hi_we_o   = wr & cmp_hit & cmp_ofs[2];
    assign mtime_lo_we_o = wr & mtime_lo_hit;
    assign mtime_hi_we_o = wr & mtime_hi_hit;

    // ----------------------------------------
    // Read mux and response
    // ----------------------------------------

    // Broadcast, clear and unmapped addresses read as zero
    always_comb begin
        rdata = '0;
        if (msip_hit) begin
            rdata[0] = msip_i[msip_idx];
        end else if (cmp_hit) begin
            rdata = cmp_ofs[2] ? mtimecmp_i[cmp_idx][clint_pkg::DATA_W +: clint_pkg::DATA_W]
                               : mtimecmp_i[cmp_idx][0 +: clint_pkg::DATA_W];
        end else if (mtime_lo_hit) begin
            rdata = mtime_i[0 +: clint_pkg::DATA_W];
        end else if (mtime_hi_hit) begin
            rdata = mtime_i[clint_pkg::DATA_W +: clint_pkg::DATA_W];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_valid_q <= 1'b0;
        end else if (accept) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    // Sampled once per request, held through back-pressure
    always_ff @(posedge clk_i) begin
        if (accept) begin
            rsp_rdata_q <= rdata;
            rsp_error_q <= error;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_rdata_o = rsp_rdata_q;
    assign rsp_error_o = rsp_error_q;

    // At most one register block is written per request
    strobe_onehot_a : assert property (
        @(posedge clk_i) disable iff (reset_i)
        $onehot0({msip_we_o, bcast_we_o, clr_we_o, cmp_lo_we_o, cmp_hi_we_o,
                  mtime_lo_we_o, mtime_hi_we_o})
    );

    rsp_stable_a : assert property (
        @(posedge clk_i) disable iff (reset_i)
        rsp_valid_o && !rsp_ready_i |=>
            rsp_valid_o && $stable(rsp_rdata_o) && $stable(rsp_error_o)
    );

endmodule

/* clint_rtc_sync.sv */
// Real-time clock input synchronizer with a rising-edge tick output
module clint_rtc_sync (
    input  logic clk_i,
    input  logic reset_i,
    input  logic rtc_i,
    output logic rtc_tick_o
);

    logic [clint_pkg::SYNC_STAGES-1:0] sync_q;
    logic                              delay_q;

    // Shift chain, rtc_i enters at bit 0
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sync_q  <= '0;
            delay_q <= 1'b0;
        end else begin
            sync_q  <= {sync_q[clint_pkg::SYNC_STAGES-2:0], rtc_i};
            delay_q <= sync_q[clint_pkg::SYNC_STAGES-1];
        end
    end

    // High for one cycle when the synchronized level goes 0 -> 1
    assign rtc_tick_o = sync_q[clint_pkg::SYNC_STAGES-1] & ~delay_q;

    // rtc_i holds each level for 3 or more cycles, so ticks are 6 or more apart
    tick_single_cycle_a : assert property (
        @(posedge clk_i) disable iff (reset_i)
        rtc_tick_o |=> !rtc_tick_o [*5]
    );

endmodule

/* clint_tb.sv */
// Directed testbench for the core-local interrupt controller over its register bus
module clint_tb;

    localparam int unsigned HALF_PERIOD    = 20;
    localparam int unsigned RTC_HOLD       = 6;
    // Well above the length of all tests together
    localparam int unsigned TIMEOUT_CYCLES = 4000;

    logic                  clk_i;
    logic                  reset_i;
    logic                  req_valid_i;
    logic                  req_ready_o;
    clint_pkg::bus_addr_t  req_addr_i;
    logic                  req_write_i;
    clint_pkg::bus_data_t  req_wdata_i;
    logic                  rsp_valid_o;
    logic                  rsp_ready_i;
    clint_pkg::bus_data_t  rsp_rdata_o;
    logic                  rsp_error_o;
    logic                  rtc_i;
    clint_pkg::hart_mask_t timer_irq_o;
    clint_pkg::hart_mask_t ipi_o;

    logic [31:0]           lcg_state = 32'h47fe_c151;

    clint_top clint_top_inst (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_addr_i  (req_addr_i),
        .req_write_i (req_write_i),
        .req_wdata_i (req_wdata_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_rdata_o (rsp_rdata_o),
        .rsp_error_o (rsp_error_o),
        .rtc_i       (rtc_i),
        .timer_irq_o (timer_irq_o),
        .ipi_o       (ipi_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #HALF_PERIOD clk_i = ~clk_i;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic clint_pkg::bus_addr_t cmp_addr(input int unsigned hart, input logic hi);
        return clint_pkg::MTIMECMP_BASE + clint_pkg::bus_addr_t'(8 * hart + (hi ? 4 : 0));
    endfunction

    function automatic clint_pkg::bus_addr_t msip_addr(input int unsigned hart);
        return clint_pkg::MSIP_BASE + clint_pkg::bus_addr_t'(4 * hart);
    endfunction

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Some tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Holds the request until the edge where it is accepted
    task automatic wait_accept();
        @(posedge clk_i);
        while (!req_ready_o) @(posedge clk_i);
        req_valid_i <= 1'b0;
        req_write_i <= 1'b0;
    endtask

    task automatic bus_write(input clint_pkg::bus_addr_t addr, input clint_pkg::bus_data_t data,
                             output logic err);
        req_valid_i <= 1'b1;
        req_addr_i  <= addr;
        req_write_i <= 1'b1;
        req_wdata_i <= data;
        rsp_ready_i <= 1'b1;
        wait_accept();
        @(posedge clk_i);
        check("rsp_valid_o", rsp_valid_o, 1'b1);
        err = rsp_error_o;
    endtask

    // hold gives the number of edges with rsp_ready_i low after rsp_valid_o rises
    task automatic bus_read(input clint_pkg::bus_addr_t addr, input int unsigned hold,
                            output clint_pkg::bus_data_t data, output logic err);
        clint_pkg::bus_data_t held_data;
        logic                 held_err;
        req_valid_i <= 1'b1;
        req_addr_i  <= addr;
        req_write_i <= 1'b0;
        req_wdata_i <= '0;
        rsp_ready_i <= (hold == 0);
        wait_accept();
        @(posedge clk_i);
        check("rsp_valid_o", rsp_valid_o, 1'b1);
        if (hold > 0) begin
            held_data = rsp_rdata_o;
            held_err  = rsp_error_o;
            repeat (hold - 1) begin
                @(posedge clk_i);
                check("rsp_valid_o", rsp_valid_o, 1'b1);
                check("req_ready_o", req_ready_o, 1'b0);
                check("rsp_rdata_o", rsp_rdata_o, held_data);
                check("rsp_error_o", rsp_error_o, held_err);
            end
            rsp_ready_i <= 1'b1;
            @(posedge clk_i);
            check("rsp_valid_o", rsp_valid_o, 1'b1);
            check("rsp_rdata_o", rsp_rdata_o, held_data);
        end
        data = rsp_rdata_o;
        err  = rsp_error_o;
    endtask

    task automatic write_reg(input clint_pkg::bus_addr_t addr, input clint_pkg::bus_data_t data);
        logic err;
        bus_write(addr, data, err);
        check($sformatf("rsp_error_o @0x%04h", addr), err, 1'b0);
    endtask

    task automatic read_expect(input clint_pkg::bus_addr_t addr,
                               input clint_pkg::bus_data_t expected);
        clint_pkg::bus_data_t data;
        logic                 err;
        bus_read(addr, 0, data, err);
        check($sformatf("rsp_error_o @0x%04h", addr), err, 1'b0);
        check($sformatf("rsp_rdata_o @0x%04h", addr), data, expected);
    endtask

    task automatic read_mtime(output clint_pkg::time_t value);
        clint_pkg::bus_data_t lo;
        clint_pkg::bus_data_t hi;
        logic                 err;
        bus_read(clint_pkg::MTIME_LO_OFS, 0, lo, err);
        check("rsp_error_o", err, 1'b0);
        bus_read(clint_pkg::MTIME_HI_OFS, 0, hi, err);
        check("rsp_error_o", err, 1'b0);
        value = {hi, lo};
    endtask

    // Each pulse is RTC_HOLD cycles high then RTC_HOLD cycles low
    task automatic toggle_rtc(input int unsigned pulses);
        repeat (pulses) begin
            rtc_i <= 1'b1;
            repeat (RTC_HOLD) @(posedge clk_i);
            rtc_i <= 1'b0;
            repeat (RTC_HOLD) @(posedge clk_i);
        end
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------

    task automatic test_reset_state();
        clint_pkg::time_t now;
        check("timer_irq_o", timer_irq_o, '0);
        check("ipi_o", ipi_o, '0);
        read_mtime(now);
        check("mtime", now, 64'h0);
        for (int h = 0; h < clint_pkg::NUM_HARTS; h++) begin
            read_expect(cmp_addr(h, 1'b0), 32'hFFFF_FFFF);
            read_expect(cmp_addr(h, 1'b1), 32'hFFFF_FFFF);
            read_expect(msip_addr(h), 32'h0);
        end
    endtask

    task automatic test_readback_errors();
        clint_pkg::bus_data_t lo_vals [clint_pkg::NUM_HARTS];
        clint_pkg::bus_data_t hi_vals [clint_pkg::NUM_HARTS];
        clint_pkg::bus_addr_t bad_addrs [3];
        clint_pkg::bus_data_t data;
        logic                 err;
        bad_addrs = '{16'h1000, 16'h4002, 16'h0010};
        for (int h = 0; h < clint_pkg::NUM_HARTS; h++) begin
            lo_vals[h] = next_random();
            hi_vals[h] = next_random();
            write_reg(cmp_addr(h, 1'b0), lo_vals[h]);
            write_reg(cmp_addr(h, 1'b1), hi_vals[h]);
        end
        for (int h = 0; h < clint_pkg::NUM_HARTS; h++) begin
            read_expect(cmp_addr(h, 1'b0), lo_vals[h]);
            read_expect(cmp_addr(h, 1'b1), hi_vals[h]);
        end
        bus_read(cmp_addr(2, 1'b0), 5, data, err);
        check("rsp_error_o", err, 1'b0);
        check("rsp_rdata_o", data, lo_vals[2]);
        // Back to all ones so later timer checks see quiet harts
        for (int h = 0; h < clint_pkg::NUM_HARTS; h++) begin
            write_reg(cmp_addr(h, 1'b0), 32'hFFFF_FFFF);
            write_reg(cmp_addr(h, 1'b1), 32'hFFFF_FFFF);
        end
        foreach (bad_addrs[i]) begin
            bus_read(bad_addrs[i], 0, data, err);
            check($sformatf("rsp_error_o @0x%04h", bad_addrs[i]), err, 1'b1);
            check($sformatf("rsp_rdata_o @0x%04h", bad_addrs[i]), data, 32'h0);
        end
        // One past the last compare pair aliases hart 0 if decoded wrongly
        bus_write(16'h4020, 32'h0, err);
        check("rsp_error_o @0x4020", err, 1'b1);
        read_expect(cmp_addr(0, 1'b0), 32'hFFFF_FFFF);
    endtask

    task automatic test_timer_count();
        clint_pkg::time_t start;
        clint_pkg::time_t now;
        start = 64'h0000_0001_FFFF_FFFC;
        write_reg(clint_pkg::MTIME_LO_OFS, start[31:0]);
        write_reg(clint_pkg::MTIME_HI_OFS, start[63:32]);
        read_mtime(now);
        check("mtime", now, start);
        toggle_rtc(6);
        read_mtime(now);
        check("mtime", now, start + 64'd6);
    endtask

    task automatic test_timer_irq();
        clint_pkg::time_t now;
        clint_pkg::time_t cmp;
        int unsigned      k;
        k = 1;
        read_mtime(now);
        cmp = now + 64'd2;
        write_reg(cmp_addr(k, 1'b0), cmp[31:0]);
        write_reg(cmp_addr(k, 1'b1), cmp[63:32]);
        check("timer_irq_o", timer_irq_o, '0);
        toggle_rtc(3);
        check("timer_irq_o", timer_irq_o, 4'b0001 << k);
        write_reg(cmp_addr(k, 1'b0), 32'hFFFF_FFFF);
        write_reg(cmp_addr(k, 1'b1), 32'hFFFF_FFFF);
        check("timer_irq_o", timer_irq_o, '0);
    endtask

    task automatic test_soft_irq();
        clint_pkg::hart_mask_t expected_ipi;
        write_reg(msip_addr(2), 32'h1);
        check("ipi_o", ipi_o, 4'b0100);
        write_reg(clint_pkg::MSIP_BCAST_OFS, 32'h0000_0103);
        check("ipi_o", ipi_o, 4'b1110);
        write_reg(clint_pkg::MSIP_CLR_OFS, 32'h1);
        check("ipi_o", ipi_o, 4'b1100);
        write_reg(clint_pkg::MSIP_CLR_OFS, 32'h7);
        expected_ipi = 4'b1100;
        check("ipi_o", ipi_o, expected_ipi);
        for (int h = 0; h < clint_pkg::NUM_HARTS; h++) begin
            read_expect(msip_addr(h), {31'b0, expected_ipi[h]});
        end
    endtask

    initial begin
        reset_i     = 1'b1;
        req_valid_i = 1'b0;
        req_addr_i  = '0;
        req_write_i = 1'b0;
        req_wdata_i = '0;
        rsp_ready_i = 1'b1;
        rtc_i       = 1'b0;
        repeat (2) @(posedge clk_i);
        reset_i <= 1'b0;

        test_reset_state();
        test_readback_errors();
        test_timer_count();
        test_timer_irq();
        test_soft_irq();

        $display("All tests passed");
        $finish;
    end

endmodule

/* clint_timecmp.sv */
// Per-hart timer compare registers and timer interrupt generation
module clint_timecmp (
    input  logic                                          clk_i,
    input  logic                                          reset_i,
    input  clint_pkg::bus_data_t                          wdata_i,
    input  clint_pkg::hart_idx_t                          hart_i,
    input  logic                                          lo_we_i,
    input  logic                                          hi_we_i,
    input  clint_pkg::time_t                              mtime_i,
    output clint_pkg::time_t [clint_pkg::NUM_HARTS-1:0]   mtimecmp_o,
    output clint_pkg::hart_mask_t                         timer_irq_o
);

    clint_pkg::time_t [clint_pkg::NUM_HARTS-1:0] cmp_q;

    // ----------------------------------------
    // Compare registers
    // ----------------------------------------

    // All ones keeps every timer interrupt low out of reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cmp_q <= '1;
        end else begin
            if (lo_we_i) begin
                cmp_q[hart_i][0 +: clint_pkg::DATA_W] <= wdata_i;
            end
            if (hi_we_i) begin
                cmp_q[hart_i][clint_pkg::DATA_W +: clint_pkg::DATA_W] <= wdata_i;
            end
        end
    end

    assign mtimecmp_o = cmp_q;

    // ----------------------------------------
    // Interrupts
    // ----------------------------------------

    // Level interrupt, stays up until the compare value moves past mtime
    always_comb begin
        for (int unsigned i = 0; i < clint_pkg::NUM_HARTS; i++) begin
            timer_irq_o[i] = (mtime_i >= cmp_q[i]);
        end
    end

endmodule

/* clint_top.f */
clint_pkg.sv
clint_rtc_sync.sv
clint_reg_bus.sv
clint_mtime.sv
clint_timecmp.sv
clint_msip.sv
clint_top.sv
clint_tb.sv

/* clint_top.sv */
// Core-local interrupt controller top level with timer, compare and software interrupt banks
module clint_top (
    input  logic                  clk_i,
    input  logic                  reset_i,

    // Register bus
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  clint_pkg::bus_addr_t  req_addr_i,
    input  logic                  req_write_i,
    input  clint_pkg::bus_data_t  req_wdata_i,
    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output clint_pkg::bus_data_t  rsp_rdata_o,
    output logic                  rsp_error_o,

    // Slow real-time clock, asynchronous to clk_i
    input  logic                  rtc_i,

    output clint_pkg::hart_mask_t timer_irq_o,
    output clint_pkg::hart_mask_t ipi_o
);

    logic                                        rtc_tick;
    clint_pkg::time_t                            mtime;
    clint_pkg::time_t [clint_pkg::NUM_HARTS-1:0] mtimecmp;
    clint_pkg::bus_data_t                        wdata;
    clint_pkg::hart_idx_t                        hart;
    logic                                        mtime_lo_we;
    logic                                        mtime_hi_we;
    logic                                        cmp_lo_we;
    logic                                        cmp_hi_we;
    logic                                        msip_we;
    logic                                        bcast_we;
    logic                                        clr_we;

    clint_rtc_sync clint_rtc_sync_inst (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rtc_i      (rtc_i),
        .rtc_tick_o (rtc_tick)
    );

    clint_reg_bus clint_reg_bus_inst (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .req_addr_i    (req_addr_i),
        .req_write_i   (req_write_i),
        .req_wdata_i   (req_wdata_i),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_ready_i   (rsp_ready_i),
        .rsp_rdata_o   (rsp_rdata_o),
        .rsp_error_o   (rsp_error_o),
        .mtime_i       (mtime),
        .mtimecmp_i    (mtimecmp),
        .msip_i        (ipi_o),
        .wdata_o       (wdata),
        .hart_o        (hart),
        .mtime_lo_we_o (mtime_lo_we),
        .mtime_hi_we_o (mtime_hi_we),
        .cmp_lo_we_o   (cmp_lo_we),
        .cmp_hi_we_o   (cmp_hi_we),
        .msip_we_o     (msip_we),
        .bcast_we_o    (bcast_we),
        .clr_we_o      (clr_we)
    );

    clint_mtime clint_mtime_inst (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rtc_tick_i (rtc_tick),
        .wdata_i    (wdata),
        .lo_we_i    (mtime_lo_we),
        .hi_we_i    (mtime_hi_we),
        .mtime_o    (mtime)
    );

    clint_timecmp clint_timecmp_inst (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .wdata_i     (wdata),
        .hart_i      (hart),
        .lo_we_i     (cmp_lo_we),
        .hi_we_i     (cmp_hi_we),
        .mtime_i     (mtime),
        .mtimecmp_o  (mtimecmp),
        .timer_irq_o (timer_irq_o)
    );

    clint_msip clint_msip_inst (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .wdata_i    (wdata),
        .hart_i     (hart),
        .msip_we_i  (msip_we),
        .bcast_we_i (bcast_we),
        .clr_we_i   (clr_we),
        .ipi_o      (ipi_o)
    );

endmodule
